//--- hw/pad_cfg.svh
`ifndef PAD_CFG_SVH
`define PAD_CFG_SVH

// Timing of the game pad reader, in clock cycles

// Length of one select phase
// 1000 cycles keeps every phase well above the pad's settling time
`define PAD_PHASE_CYCLES 1000

// Interval between automatic polls
// Must be longer than the eight phases of a read cycle
`define PAD_POLL_CYCLES 12000

// Flip-flops in the pin synchronizer
`define PAD_SYNC_STAGES 2

`endif

//--- hw/pad_pkg.sv
package pad_pkg;

	// Pad pins as seen at the connector, active low
	// Bit order follows the connector pins 1, 2, 3, 4, 6, 9
	typedef logic [5:0] pad_pins_t;

	// Position of each connector pin inside pad_pins_t
	typedef enum logic [2:0] {
		PIN_1 = 3'd0,
		PIN_2 = 3'd1,
		PIN_3 = 3'd2,
		PIN_4 = 3'd3,
		PIN_6 = 3'd4,
		PIN_9 = 3'd5
	} pad_pin_idx_t;

	// Which group of buttons the pins carry in the current phase
	typedef enum logic [2:0] {
		PHASE_IDLE         = 3'd0,
		PHASE_DPAD_B_C     = 3'd1,
		PHASE_DPAD_A_START = 3'd2,
		PHASE_ID_A_START   = 3'd3,
		PHASE_XYZ_MODE_B_C = 3'd4,
		PHASE_TRAILER      = 3'd5
	} pad_phase_t;

	// Decoded button word, a set bit means pressed
	typedef logic [11:0] pad_buttons_t;

	// Bit positions inside pad_buttons_t
	typedef enum logic [3:0] {
		BTN_UP    = 4'd0,
		BTN_DOWN  = 4'd1,
		BTN_LEFT  = 4'd2,
		BTN_RIGHT = 4'd3,
		BTN_A     = 4'd4,
		BTN_B     = 4'd5,
		BTN_C     = 4'd6,
		BTN_X     = 4'd7,
		BTN_Y     = 4'd8,
		BTN_Z     = 4'd9,
		BTN_START = 4'd10,
		BTN_MODE  = 4'd11
	} pad_button_idx_t;

endpackage

//--- hw/pad_poll_timer.sv
`timescale 1ns/1ps

`include "pad_cfg.svh"

module pad_poll_timer (
	input  logic clock,
	input  logic reset_n,
	input  logic poll_enable,
	input  logic poll_now,
	output logic poll_strobe
);

	localparam int POLL_CYCLES = `PAD_POLL_CYCLES;
	localparam int CNT_W = (POLL_CYCLES > 1) ? $clog2(POLL_CYCLES) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(POLL_CYCLES - 1);

	logic [CNT_W-1:0] period_count;

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			period_count <= '0;
			poll_strobe  <= 1'b0;
		end else if (poll_now) begin
			// Manual request fires at once and restarts the period
			period_count <= '0;
			poll_strobe  <= 1'b1;
		end else if (poll_enable) begin
			if (period_count == CNT_LAST) begin
				period_count <= '0;
				poll_strobe  <= 1'b1;
			end else begin
				period_count <= period_count + 1'b1;
				poll_strobe  <= 1'b0;
			end
		end else begin
			// Disabled, so the next enable starts a full period
			period_count <= '0;
			poll_strobe  <= 1'b0;
		end
	end

endmodule

//--- hw/pad_phase_sequencer.sv
`timescale 1ns/1ps

`include "pad_cfg.svh"

module pad_phase_sequencer import pad_pkg::*; (
	input  logic       clock,
	input  logic       reset_n,
	input  logic       poll_strobe,
	output logic       pad_select,
	output pad_phase_t phase,
	output logic       sample,
	output logic       done
);

	localparam int PHASE_CYCLES = `PAD_PHASE_CYCLES;
	localparam int CNT_W = (PHASE_CYCLES > 1) ? $clog2(PHASE_CYCLES) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(PHASE_CYCLES - 1);

	// Idle plus one state per select phase
	typedef enum logic [3:0] {
		ST_IDLE = 4'd0,
		ST_PH0  = 4'd1,
		ST_PH1  = 4'd2,
		ST_PH2  = 4'd3,
		ST_PH3  = 4'd4,
		ST_PH4  = 4'd5,
		ST_PH5  = 4'd6,
		ST_PH6  = 4'd7,
		ST_PH7  = 4'd8
	} state_t;

	state_t           state;
	state_t           state_next;
	logic [CNT_W-1:0] phase_count;
	logic             phase_last;

	// Last cycle of the running phase
	assign phase_last = (state != ST_IDLE) && (phase_count == CNT_LAST);

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				// Polls arriving mid cycle are simply dropped
				if (poll_strobe) begin
					state_next = ST_PH0;
				end
			end
			ST_PH7: begin
				if (phase_last) begin
					state_next = ST_IDLE;
				end
			end
			ST_PH0, ST_PH1, ST_PH2, ST_PH3, ST_PH4, ST_PH5, ST_PH6: begin
				if (phase_last) begin
					state_next = state_t'(state + 4'd1);
				end
			end
			default: begin
				state_next = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Phase length counter, parked at zero while idle
	always_ff @(posedge clock) begin
		if (!reset_n) begin
			phase_count <= '0;
		end else if (state == ST_IDLE || phase_last) begin
			phase_count <= '0;
		end else begin
			phase_count <= phase_count + 1'b1;
		end
	end

	// Select level and pin group for each phase
	always_comb begin
		case (state)
			ST_PH0, ST_PH2, ST_PH4: begin
				pad_select = 1'b1;
				phase      = PHASE_DPAD_B_C;
			end
			ST_PH1, ST_PH3: begin
				pad_select = 1'b0;
				phase      = PHASE_DPAD_A_START;
			end
			ST_PH5: begin
				// Third low, a six-button pad pulls pins 1 to 4 low here
				pad_select = 1'b0;
				phase      = PHASE_ID_A_START;
			end
			ST_PH6: begin
				pad_select = 1'b1;
				phase      = PHASE_XYZ_MODE_B_C;
			end
			ST_PH7: begin
				pad_select = 1'b0;
				phase      = PHASE_TRAILER;
			end
			default: begin
				pad_select = 1'b0;
				phase      = PHASE_IDLE;
			end
		endcase
	end

	assign sample = phase_last;

	// Cycle complete, raised while the FSM is already back in idle
	always_ff @(posedge clock) begin
		if (!reset_n) begin
			done <= 1'b0;
		end else begin
			done <= (state == ST_PH7) && phase_last;
		end
	end

endmodule

//--- hw/pad_button_decoder.sv
`timescale 1ns/1ps

`include "pad_cfg.svh"

module pad_button_decoder import pad_pkg::*; (
	input  logic         clock,
	input  logic         reset_n,
	input  pad_pins_t    pad_pins,
	input  pad_phase_t   phase,
	input  logic         sample,
	input  logic         done,
	output pad_buttons_t buttons,
	output logic         six_button,
	output logic         connected,
	output logic         buttons_valid
);

	localparam int SYNC_STAGES = `PAD_SYNC_STAGES;

	// Buttons that only a six-button pad provides
	localparam pad_buttons_t EXTRA_MASK = (pad_buttons_t'(1) << BTN_X)
		| (pad_buttons_t'(1) << BTN_Y)
		| (pad_buttons_t'(1) << BTN_Z)
		| (pad_buttons_t'(1) << BTN_MODE);

	pad_pins_t    sync_q [SYNC_STAGES];
	pad_pins_t    pressed;
	pad_buttons_t work_buttons;
	logic         work_connected;
	logic         work_six;

	// Pins are asynchronous to the clock
	always_ff @(posedge clock) begin
		sync_q[0] <= pad_pins;
		for (int i = 1; i < SYNC_STAGES; i++) begin
			sync_q[i] <= sync_q[i-1];
		end
	end

	// Low at the connector means pressed
	assign pressed = ~sync_q[SYNC_STAGES-1];

	// Working result, one pin group per phase
	always_ff @(posedge clock) begin
		if (sample) begin
			case (phase)
				PHASE_DPAD_B_C: begin
					work_buttons[BTN_UP]    <= pressed[PIN_1];
					work_buttons[BTN_DOWN]  <= pressed[PIN_2];
					work_buttons[BTN_LEFT]  <= pressed[PIN_3];
					work_buttons[BTN_RIGHT] <= pressed[PIN_4];
					work_buttons[BTN_B]     <= pressed[PIN_6];
					work_buttons[BTN_C]     <= pressed[PIN_9];
				end
				PHASE_DPAD_A_START: begin
					work_buttons[BTN_UP]    <= pressed[PIN_1];
					work_buttons[BTN_DOWN]  <= pressed[PIN_2];
					work_buttons[BTN_A]     <= pressed[PIN_6];
					work_buttons[BTN_START] <= pressed[PIN_9];
					// A pad ties pins 3 and 4 low while select is low
					work_connected          <= pressed[PIN_3] & pressed[PIN_4];
				end
				PHASE_ID_A_START: begin
					work_buttons[BTN_A]     <= pressed[PIN_6];
					work_buttons[BTN_START] <= pressed[PIN_9];
					work_six                <= &pressed[PIN_4:PIN_1];
				end
				PHASE_XYZ_MODE_B_C: begin
					work_buttons[BTN_Z]    <= pressed[PIN_1];
					work_buttons[BTN_Y]    <= pressed[PIN_2];
					work_buttons[BTN_X]    <= pressed[PIN_3];
					work_buttons[BTN_MODE] <= pressed[PIN_4];
					work_buttons[BTN_B]    <= pressed[PIN_6];
					work_buttons[BTN_C]    <= pressed[PIN_9];
				end
				default: begin
					// Idle and trailer carry nothing
				end
			endcase
		end
	end

	// Result register, held until the next commit
	always_ff @(posedge clock) begin
		if (!reset_n) begin
			buttons       <= '0;
			six_button    <= 1'b0;
			connected     <= 1'b0;
			buttons_valid <= 1'b0;
		end else begin
			buttons_valid <= done;
			if (done) begin
				connected  <= work_connected;
				six_button <= work_connected & work_six;
				if (!work_connected) begin
					buttons <= '0;
				end else if (!work_six) begin
					// Three-button pad repeats the d-pad in the extra phase
					buttons <= work_buttons & ~EXTRA_MASK;
				end else begin
					buttons <= work_buttons;
				end
			end
		end
	end

endmodule

//--- hw/pad_reader_top.sv
`timescale 1ns/1ps

module pad_reader_top import pad_pkg::*; (
	input  logic         clock,
	input  logic         reset_n,
	input  logic         poll_enable,
	input  logic         poll_now,
	input  pad_pins_t    pad_pins,
	output logic         pad_select,
	output pad_buttons_t buttons,
	output logic         six_button,
	output logic         connected,
	output logic         buttons_valid
);

	logic       poll_strobe;
	pad_phase_t phase;
	logic       sample;
	logic       done;

	// Starts a read cycle periodically or on request
	pad_poll_timer i_timer (
		.clock       (clock),
		.reset_n     (reset_n),
		.poll_enable (poll_enable),
		.poll_now    (poll_now),
		.poll_strobe (poll_strobe)
	);

	// Drives select and tells the decoder what the pins mean
	pad_phase_sequencer i_sequencer (
		.clock       (clock),
		.reset_n     (reset_n),
		.poll_strobe (poll_strobe),
		.pad_select  (pad_select),
		.phase       (phase),
		.sample      (sample),
		.done        (done)
	);

	pad_button_decoder i_decoder (
		.clock         (clock),
		.reset_n       (reset_n),
		.pad_pins      (pad_pins),
		.phase         (phase),
		.sample        (sample),
		.done          (done),
		.buttons       (buttons),
		.six_button    (six_button),
		.connected     (connected),
		.buttons_valid (buttons_valid)
	);

endmodule

//--- testbench/pad_model.sv
`timescale 1ns/1ps

`include "pad_cfg.svh"

module pad_model import pad_pkg::*; (
	input  logic         clock,
	input  logic         pad_select,
	input  pad_buttons_t pressed,
	input  logic         six_button,
	input  logic         connected,
	output pad_pins_t    pad_pins
);

	// Select sitting still this long restarts the pad's internal count
	localparam int QUIET_CYCLES = (`PAD_PHASE_CYCLES * 3) / 2;

	logic      select_q = 1'b0;
	int        falls = 0;
	int        quiet = 0;
	pad_pins_t grounded;

	// Falling edges of select since the last quiet period
	always @(posedge clock) begin
		select_q <= pad_select;
		if (pad_select != select_q) begin
			quiet <= 0;
			if (!pad_select) begin
				falls <= falls + 1;
			end
		end else if (quiet >= QUIET_CYCLES) begin
			falls <= 0;
		end else begin
			quiet <= quiet + 1;
		end
	end

	// Pins pulled low by the pad, active high here
	always_comb begin
		grounded = '0;
		if (pad_select) begin
			grounded[PIN_6] = pressed[BTN_B];
			grounded[PIN_9] = pressed[BTN_C];
			if (six_button && falls == 3) begin
				// Fourth high carries the extra group
				grounded[PIN_1] = pressed[BTN_Z];
				grounded[PIN_2] = pressed[BTN_Y];
				grounded[PIN_3] = pressed[BTN_X];
				grounded[PIN_4] = pressed[BTN_MODE];
			end else begin
				grounded[PIN_1] = pressed[BTN_UP];
				grounded[PIN_2] = pressed[BTN_DOWN];
				grounded[PIN_3] = pressed[BTN_LEFT];
				grounded[PIN_4] = pressed[BTN_RIGHT];
			end
		end else begin
			grounded[PIN_6] = pressed[BTN_A];
			grounded[PIN_9] = pressed[BTN_START];
			if (six_button && falls == 3) begin
				grounded[3:0] = 4'hf;
			end else if (six_button && falls >= 4) begin
				grounded[3:0] = 4'h0;
			end else begin
				grounded[PIN_1] = pressed[BTN_UP];
				grounded[PIN_2] = pressed[BTN_DOWN];
				grounded[PIN_3] = 1'b1;
				grounded[PIN_4] = 1'b1;
			end
		end
		// Open connector, pull-ups win
		if (!connected) begin
			grounded = '0;
		end
	end

	assign pad_pins = ~grounded;

endmodule

//--- testbench/tb_pad_reader.sv
`timescale 1ns/1ps

`include "pad_cfg.svh"

module tb_pad_reader import pad_pkg::*; ();

	localparam int PHASE = `PAD_PHASE_CYCLES;
	localparam int POLL = `PAD_POLL_CYCLES;
	localparam int CYCLE_TIMEOUT = 9 * PHASE;
	localparam int IDLE_GAP = 2 * PHASE;
	localparam int NUM_ENTRIES = 10;
	// X, Y, Z and mode
	localparam pad_buttons_t EXTRA_BITS = 12'hb80;

	logic         clock;
	logic         reset_n;
	logic         poll_enable;
	logic         poll_now;
	pad_pins_t    pad_pins;
	logic         pad_select;
	pad_buttons_t buttons;
	logic         six_button;
	logic         connected;
	logic         buttons_valid;
	pad_buttons_t model_pressed;
	logic         model_six;
	logic         model_connected;

	// Stimulus table
	string        names [NUM_ENTRIES];
	pad_buttons_t press_tab [NUM_ENTRIES];
	logic         six_tab [NUM_ENTRIES];
	logic         conn_tab [NUM_ENTRIES];

	int error_count = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	pad_reader_top i_dut (
		.clock         (clock),
		.reset_n       (reset_n),
		.poll_enable   (poll_enable),
		.poll_now      (poll_now),
		.pad_pins      (pad_pins),
		.pad_select    (pad_select),
		.buttons       (buttons),
		.six_button    (six_button),
		.connected     (connected),
		.buttons_valid (buttons_valid)
	);

	pad_model i_pad (
		.clock      (clock),
		.pad_select (pad_select),
		.pressed    (model_pressed),
		.six_button (model_six),
		.connected  (model_connected),
		.pad_pins   (pad_pins)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic pad_buttons_t expected_buttons(pad_buttons_t pressed, logic six,
			logic conn);
		if (!conn) begin
			return '0;
		end
		if (!six) begin
			return pressed & ~EXTRA_BITS;
		end
		return pressed;
	endfunction

	task automatic check_buttons(input string name, input pad_buttons_t exp,
			input pad_buttons_t act);
		if (act !== exp) begin
			$display("ERR %s buttons: expected %03h, actual %03h", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_flag(input string name, input string what, input logic exp,
			input logic act);
		if (act !== exp) begin
			$display("ERR %s %s: expected %b, actual %b", name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_result(input string name, input pad_buttons_t pressed,
			input logic six, input logic conn);
		check_buttons(name, expected_buttons(pressed, six, conn), buttons);
		check_flag(name, "six_button", six & conn, six_button);
		check_flag(name, "connected", conn, connected);
	endtask

	// Returns at a falling edge with outputs settled
	task automatic wait_valid(input string name, input int limit, output logic seen);
		seen = 1'b0;
		for (int i = 0; i < limit && !seen; i++) begin
			@(negedge clock);
			seen = (buttons_valid === 1'b1);
		end
		if (!seen) begin
			$display("Timeout in test %s: no buttons_valid within %0d cycles", name, limit);
			test_errors++;
		end
	endtask

	task automatic idle_wait(input int cycles);
		repeat (cycles) @(negedge clock);
	endtask

	task automatic pulse_poll_now();
		@(negedge clock);
		poll_now = 1'b1;
		@(negedge clock);
		poll_now = 1'b0;
	endtask

	task automatic set_model(input pad_buttons_t pressed, input logic six, input logic conn);
		model_pressed   = pressed;
		model_six       = six;
		model_connected = conn;
	endtask

	task automatic add_entry(input int idx, input string name, input pad_buttons_t pressed,
			input logic six, input logic conn);
		names[idx]     = name;
		press_tab[idx] = pressed;
		six_tab[idx]   = six;
		conn_tab[idx]  = conn;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		error_count += test_errors;
		if (test_errors != 0) begin
			tests_failed++;
			$display("test %-12s failed with %0d errors", name, test_errors);
		end else begin
			$display("test %-12s ok", name);
		end
		test_errors = 0;
	endtask

	task automatic apply_table_entry(input int idx);
		logic seen;
		set_model(press_tab[idx], six_tab[idx], conn_tab[idx]);
		idle_wait(IDLE_GAP);
		pulse_poll_now();
		wait_valid(names[idx], CYCLE_TIMEOUT, seen);
		if (seen) begin
			check_result(names[idx], press_tab[idx], six_tab[idx], conn_tab[idx]);
		end
		end_test(names[idx]);
	endtask

	// Timer driven polls, a new pattern before each cycle
	task automatic poll_automatically();
		logic         seen;
		pad_buttons_t pattern;
		pad_buttons_t previous;
		previous = '0;
		idle_wait(IDLE_GAP);
		poll_enable = 1'b1;
		for (int n = 0; n < 3; n++) begin
			pattern = pad_buttons_t'($urandom);
			if (pattern == previous) begin
				pattern = ~previous;
			end
			set_model(pattern, 1'b1, 1'b1);
			wait_valid("auto_poll", POLL + 8 * PHASE + 2, seen);
			if (seen) begin
				check_result("auto_poll", pattern, 1'b1, 1'b1);
			end
			previous = pattern;
		end
		poll_enable = 1'b0;
		end_test("auto_poll");
	endtask

	task automatic poll_while_busy();
		logic         seen;
		int           extra;
		pad_buttons_t pattern;
		pattern = pad_buttons_t'($urandom);
		set_model(pattern, 1'b1, 1'b1);
		idle_wait(IDLE_GAP);
		pulse_poll_now();
		idle_wait(3 * PHASE);
		// Second request lands mid cycle
		pulse_poll_now();
		wait_valid("busy_poll", CYCLE_TIMEOUT, seen);
		if (seen) begin
			check_result("busy_poll", pattern, 1'b1, 1'b1);
		end
		extra = 0;
		for (int i = 0; i < CYCLE_TIMEOUT; i++) begin
			@(negedge clock);
			if (buttons_valid === 1'b1) begin
				extra++;
			end
		end
		if (extra != 0) begin
			$display("Test busy_poll saw %0d extra buttons_valid pulses", extra);
			test_errors++;
		end
		end_test("busy_poll");
	endtask

	task automatic reset_mid_cycle();
		logic         seen;
		pad_buttons_t pattern;
		pattern = pad_buttons_t'($urandom);
		set_model(pattern, 1'b1, 1'b1);
		idle_wait(IDLE_GAP);
		pulse_poll_now();
		idle_wait(4 * PHASE);
		reset_n = 1'b0;
		idle_wait(3);
		reset_n = 1'b1;
		@(negedge clock);
		check_flag("mid_reset", "pad_select", 1'b0, pad_select);
		check_buttons("mid_reset", '0, buttons);
		check_flag("mid_reset", "six_button", 1'b0, six_button);
		check_flag("mid_reset", "connected", 1'b0, connected);
		check_flag("mid_reset", "buttons_valid", 1'b0, buttons_valid);
		idle_wait(IDLE_GAP);
		pulse_poll_now();
		wait_valid("mid_reset", CYCLE_TIMEOUT, seen);
		if (seen) begin
			check_result("mid_reset", pattern, 1'b1, 1'b1);
		end
		end_test("mid_reset");
	endtask

	initial begin
		void'($urandom(32'ha867_5709));
		reset_n     = 1'b0;
		poll_enable = 1'b0;
		poll_now    = 1'b0;
		set_model('0, 1'b1, 1'b1);

		add_entry(0, "six_rand_0", pad_buttons_t'($urandom), 1'b1, 1'b1);
		add_entry(1, "six_rand_1", pad_buttons_t'($urandom), 1'b1, 1'b1);
		add_entry(2, "six_rand_2", pad_buttons_t'($urandom), 1'b1, 1'b1);
		add_entry(3, "six_all", 12'hfff, 1'b1, 1'b1);
		add_entry(4, "six_none", 12'h000, 1'b1, 1'b1);
		// Three-button pads never hold up and down together
		add_entry(5, "three_xyz", 12'hf81, 1'b0, 1'b1);
		add_entry(6, "three_dpad", 12'h06e, 1'b0, 1'b1);
		add_entry(7, "three_none", 12'h000, 1'b0, 1'b1);
		add_entry(8, "open_six", 12'habc, 1'b1, 1'b0);
		add_entry(9, "open_three", 12'h123, 1'b0, 1'b0);

		repeat (3) @(negedge clock);
		reset_n = 1'b1;

		for (int idx = 0; idx < NUM_ENTRIES; idx++) begin
			apply_table_entry(idx);
		end
		poll_automatically();
		poll_while_busy();
		reset_mid_cycle();

		$display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
			error_count);
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- pad_reader_top.f
+incdir+hw
hw/pad_pkg.sv
hw/pad_poll_timer.sv
hw/pad_phase_sequencer.sv
hw/pad_button_decoder.sv
hw/pad_reader_top.sv
testbench/pad_model.sv
testbench/tb_pad_reader.sv
